// ==== verification/returnPredictorInput.txt ====
# fetchValid fetchPc brValid brOffs brIsCall updKind updAddr updIdx updCompr setIdx restoreIdx
# then expected: predValid predOffs predCompr stackTop curIdx (all hex, updKind 0 none 1 call 2 ret 3 clean)
# reset state
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# decode call, call, return, then a fetch of the learned block
0 0 0 0 0 1 1000 0 0 0 0 0 0 0 0 0
0 0 0 0 0 1 2000 1 0 0 0 0 0 0 1001 1
0 0 0 0 0 2 24D 2 1 0 0 0 0 0 2001 2
1 24A 0 0 0 0 0 0 0 0 0 1 5 1 1001 1
# fetch push, learn two sites in set 2, nearest hit, suppressed pop, pop wrap
1 300 1 3 1 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 304 1
0 0 0 0 0 2 B6 2 0 0 0 0 0 0 304 1
1 B0 0 0 0 0 0 0 0 0 0 1 6 0 304 1
0 0 0 0 0 2 B2 2 1 0 0 0 0 0 0 0
1 B0 1 1 0 0 0 0 0 0 0 1 2 1 304 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 304 1
1 B3 0 0 0 0 0 0 0 0 0 1 6 0 304 1
1 B7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 B2 1 2 1 0 0 0 0 0 0 1 2 1 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
# decode call beats a fetch pop, setIdx loses to a fetch push then applies alone
1 B0 0 0 0 1 4000 0 0 0 0 1 2 1 0 3
0 0 0 0 0 0 0 0 0 0 0 0 0 0 4001 1
1 300 1 5 1 0 0 0 0 1 3 0 0 0 4001 1
0 0 0 0 0 0 0 0 0 1 3 0 0 0 306 2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
# clean set 2, then used-bit replacement and repeated return in set 3
0 0 0 0 0 3 B0 0 0 0 0 0 0 0 0 3
1 B0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
0 0 0 0 0 2 43C 0 0 0 0 0 0 0 0 3
1 438 0 0 0 0 0 0 0 0 0 1 4 0 0 3
0 0 0 0 0 2 43E 3 1 0 0 0 0 0 306 2
0 0 0 0 0 2 439 3 1 0 0 0 0 0 306 2
1 43D 1 0 0 0 0 0 0 0 0 0 0 0 306 2
1 438 1 0 0 0 0 0 0 0 0 1 1 1 306 2
1 43A 1 0 0 0 0 0 0 0 0 1 4 0 306 2
0 0 0 0 0 2 43C 3 0 0 0 0 0 0 306 2
1 438 1 0 0 0 0 0 0 0 0 1 1 1 306 2
# five pushes wrap the index and overwrite the oldest slot
0 0 0 0 0 1 5000 2 0 0 0 0 0 0 306 2
0 0 0 0 0 1 5010 3 0 0 0 0 0 0 5001 3
0 0 0 0 0 1 5020 0 0 0 0 0 0 0 5011 0
0 0 0 0 0 1 5030 1 0 0 0 0 0 0 5021 1
0 0 0 0 0 1 5040 2 0 0 0 0 0 0 5031 2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 5041 3
0 0 0 0 0 0 0 0 0 1 0 0 0 0 5041 3
0 0 0 0 0 0 0 0 0 0 0 0 0 0 5011 0

// ==== verilog.f ====
+incdir+verification
hw/predConfigPkg.sv
hw/predTypesPkg.sv
hw/retSiteTable.sv
hw/retAddrStack.sv
hw/returnPredictor.sv
verification/returnPredictorTb.sv

// ==== runSim.sh ====
#!/bin/sh
# builds the return predictor testbench with Verilator and runs it from the project root

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=returnPredictorSim

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module returnPredictorTb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi
exit 0

// ==== verification/returnPredictorChecks.svh ====
`ifndef RETURN_PREDICTOR_CHECKS_SVH
`define RETURN_PREDICTOR_CHECKS_SVH

// offset and compressed bit are only compared while a prediction is expected
task automatic checkPred(
    input logic      actValid,
    input FetchOff_t actOffs,
    input logic      actCompr,
    input PcHw_t     actDst,
    input logic      expValid,
    input FetchOff_t expOffs,
    input logic      expCompr,
    input PcHw_t     expDst
);
    if (actValid !== expValid) begin
        reportMismatch($sformatf("predValid is %b, expected %b", actValid, expValid));
    end else if (expValid && actOffs !== expOffs) begin
        reportMismatch($sformatf("predOffs is %0d, expected %0d", actOffs, expOffs));
    end else if (expValid && actCompr !== expCompr) begin
        reportMismatch($sformatf("predCompr is %b, expected %b", actCompr, expCompr));
    end else if (actDst !== expDst) begin
        reportMismatch($sformatf("predDst is %h, expected %h", actDst, expDst));
    end
endtask

task automatic checkIdx(input RetStackIdx_t actIdx, input RetStackIdx_t expIdx);
    if (actIdx !== expIdx) begin
        reportMismatch($sformatf("curIdx is %0d, expected %0d", actIdx, expIdx));
    end
endtask

task automatic checkAddr(input PcHw_t actAddr, input PcHw_t expAddr);
    if (actAddr !== expAddr) begin
        reportMismatch($sformatf("lateRetAddr is %h, expected %h", actAddr, expAddr));
    end
endtask

`endif

// ==== verification/returnPredictorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module returnPredictorTb
    import predConfigPkg::*;
    import predTypesPkg::*;
();

    localparam int    CLK_PERIOD     = 10;
    localparam int    RESET_CYCLES   = 10;
    localparam int    WATCHDOG_SLACK = 50;
    localparam string VEC_FILE       = "verification/returnPredictorInput.txt";

    logic         clk;
    logic         rst;

    logic         fetchValid;
    PcHw_t        fetchPc;
    logic         brValid;
    FetchOff_t    brOffs;
    logic         brIsCall;
    RetUpdKind_t  updKind;
    PcHw_t        updAddr;
    RetStackIdx_t updIdx;
    logic         updCompr;
    logic         setIdx;
    RetStackIdx_t restoreIdx;

    logic         predValid;
    FetchOff_t    predOffs;
    logic         predCompr;
    PcHw_t        predDst;
    PcHw_t        lateRetAddr;
    RetStackIdx_t curIdx;

    // expected results of the vector currently applied
    logic         expValid;
    FetchOff_t    expOffs;
    logic         expCompr;
    PcHw_t        expTop;
    RetStackIdx_t expIdx;

    string        vecLines[$];
    int           vecCount;
    int           curVec;

    returnPredictor returnPredictor_i (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchPc     (fetchPc),
        .brValid     (brValid),
        .brOffs      (brOffs),
        .brIsCall    (brIsCall),
        .updKind     (updKind),
        .updAddr     (updAddr),
        .updIdx      (updIdx),
        .updCompr    (updCompr),
        .setIdx      (setIdx),
        .restoreIdx  (restoreIdx),
        .predValid   (predValid),
        .predOffs    (predOffs),
        .predCompr   (predCompr),
        .predDst     (predDst),
        .lateRetAddr (lateRetAddr),
        .curIdx      (curIdx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic reportMismatch(input string what);
        $display("[FAIL] %0t ns: vector %0d, %s", $time, curVec, what);
        $display("Test failed");
        $fatal(1, "output mismatch");
    endtask

    `include "returnPredictorChecks.svh"

    // comment lines start with '#', every other line is one vector
    task automatic loadVectors();
        int    fd;
        string line;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", VEC_FILE);
            $display("Test failed");
            $fatal(1, "missing stimulus file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    vecLines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic applyVector(input string line);
        int          n;
        logic [31:0] f [16];
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
        if (n != 16) begin
            $display("vector %0d in the stimulus file has %0d fields instead of 16", curVec, n);
            $display("Test failed");
            $fatal(1, "malformed stimulus line");
        end else begin
            fetchValid = f[0][0];
            fetchPc    = f[1][30:0];
            brValid    = f[2][0];
            brOffs     = f[3][FETCH_OFF_LEN-1:0];
            brIsCall   = f[4][0];
            updKind    = RetUpdKind_t'(f[5][1:0]);
            updAddr    = f[6][30:0];
            updIdx     = f[7][$bits(RetStackIdx_t)-1:0];
            updCompr   = f[8][0];
            setIdx     = f[9][0];
            restoreIdx = f[10][$bits(RetStackIdx_t)-1:0];
            expValid   = f[11][0];
            expOffs    = f[12][FETCH_OFF_LEN-1:0];
            expCompr   = f[13][0];
            expTop     = f[14][30:0];
            expIdx     = f[15][$bits(RetStackIdx_t)-1:0];
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        fetchValid = 1'b0;
        fetchPc    = '0;
        brValid    = 1'b0;
        brOffs     = '0;
        brIsCall   = 1'b0;
        updKind    = UPD_NONE;
        updAddr    = '0;
        updIdx     = '0;
        updCompr   = 1'b0;
        setIdx     = 1'b0;
        restoreIdx = '0;
        vecCount   = 0;
        curVec     = 0;

        loadVectors();
        if (vecLines.size() == 0) begin
            $display("the stimulus file holds no vectors");
            $display("Test failed");
            $fatal(1, "empty stimulus file");
        end else begin
            vecCount = vecLines.size();
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (vecLines[i]) begin
                curVec = i + 1;
                applyVector(vecLines[i]);
                // outputs are combinational, sample them just before the next rising edge
                #(CLK_PERIOD / 2 - 1);
                checkPred(predValid, predOffs, predCompr, predDst,
                          expValid, expOffs, expCompr, expTop);
                checkAddr(lateRetAddr, expTop);
                checkIdx(curIdx, expIdx);
                @(negedge clk);
            end
            $display("Test passed");
            $finish;
        end
    end

    // one clock per vector plus the reset and some slack
    initial begin
        wait (vecCount > 0);
        #((RESET_CYCLES + vecCount + WATCHDOG_SLACK) * CLK_PERIOD);
        $display("timeout: %0d vectors did not finish in the allowed time", vecCount);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== hw/returnPredictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module returnPredictor
    import predTypesPkg::*;
(
    input  wire               clk,
    input  wire               rst,

    // first branch the BTB found in the fetch block
    input  wire               fetchValid,
    input  wire PcHw_t        fetchPc,
    input  wire               brValid,
    input  wire FetchOff_t    brOffs,
    input  wire               brIsCall,

    // corrections from decode
    input  wire RetUpdKind_t  updKind,
    input  wire PcHw_t        updAddr,
    input  wire RetStackIdx_t updIdx,
    input  wire               updCompr,

    // mispredict recovery
    input  wire               setIdx,
    input  wire RetStackIdx_t restoreIdx,

    output logic              predValid,
    output FetchOff_t         predOffs,
    output logic              predCompr,
    output PcHw_t             predDst,
    output PcHw_t             lateRetAddr,
    output RetStackIdx_t      curIdx
);

    logic      hit;
    FetchOff_t hitOffs;
    logic      hitCompr;
    logic      popTaken;
    PcHw_t     topAddr;

    retSiteTable retSiteTable_i (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .updKind    (updKind),
        .updAddr    (updAddr),
        .updCompr   (updCompr),
        .popTaken   (popTaken),
        .hit        (hit),
        .hitOffs    (hitOffs),
        .hitCompr   (hitCompr)
    );

    retAddrStack retAddrStack_i (
        .clk        (clk),
        .rst        (rst),
        .brValid    (brValid),
        .brOffs     (brOffs),
        .brIsCall   (brIsCall),
        .fetchPc    (fetchPc),
        .hit        (hit),
        .hitOffs    (hitOffs),
        .updKind    (updKind),
        .updAddr    (updAddr),
        .updIdx     (updIdx),
        .setIdx     (setIdx),
        .restoreIdx (restoreIdx),
        .popTaken   (popTaken),
        .curIdx     (curIdx),
        .topAddr    (topAddr)
    );

    // the predicted return target is simply the current stack top
    assign predValid   = hit;
    assign predOffs    = hitOffs;
    assign predCompr   = hitCompr;
    assign predDst     = topAddr;
    assign lateRetAddr = topAddr;

endmodule

`default_nettype wire

// ==== hw/retAddrStack.sv ====
`timescale 1ns/1ps
`default_nettype none

module retAddrStack
    import predConfigPkg::*;
    import predTypesPkg::*;
(
    input  wire               clk,
    input  wire               rst,

    input  wire               brValid,
    input  wire FetchOff_t    brOffs,
    input  wire               brIsCall,
    input  wire PcHw_t        fetchPc,

    input  wire               hit,
    input  wire FetchOff_t    hitOffs,

    input  wire RetUpdKind_t  updKind,
    input  wire PcHw_t        updAddr,
    input  wire RetStackIdx_t updIdx,

    input  wire               setIdx,
    input  wire RetStackIdx_t restoreIdx,

    output logic              popTaken,
    output RetStackIdx_t      curIdx,
    output PcHw_t             topAddr
);

    PcHw_t        stackMem [RET_STACK_SIZE];
    RetStackIdx_t stackIdx;

    RetStackIdx_t curNext;
    RetStackIdx_t curPrev;
    RetStackIdx_t updNext;
    RetStackIdx_t updPrev;

    logic         updPresent;
    logic         fetchPush;
    PcHw_t        fetchPushAddr;

    // the index is a power-of-two width, so these wrap around the circular stack
    assign curNext = stackIdx + 1'b1;
    assign curPrev = stackIdx - 1'b1;
    assign updNext = updIdx + 1'b1;
    assign updPrev = updIdx - 1'b1;

    // decode corrections override anything fetch wants to do this cycle
    assign updPresent = (updKind != UPD_NONE);

    // a return is taken unless an earlier branch in the block leaves first
    assign popTaken  = !updPresent && hit && (!brValid || brOffs >= hitOffs);
    assign fetchPush = !updPresent && !popTaken && brValid && brIsCall;

    // return lands on the halfword after the call
    assign fetchPushAddr = {fetchPc[$bits(PcHw_t)-1:FETCH_OFF_LEN], brOffs} + 1'b1;

    assign curIdx  = stackIdx;
    assign topAddr = stackMem[stackIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            stackIdx <= '0;
            for (int i = 0; i < RET_STACK_SIZE; i++) begin
                stackMem[i] <= '0;
            end
        end else begin
            if (updKind == UPD_CALL) begin
                stackMem[updNext] <= updAddr + 1'b1;
                stackIdx          <= updNext;
            end else if (updKind == UPD_RET) begin
                stackIdx <= updPrev;
            end else if (popTaken) begin
                stackIdx <= curPrev;
            end else if (fetchPush) begin
                stackMem[curNext] <= fetchPushAddr;
                stackIdx          <= curNext;
            end else if (setIdx) begin
                // a clean request leaves the index alone, so a restore still goes through
                stackIdx <= restoreIdx;
            end
        end
    end

    updKindKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(updKind));

endmodule

`default_nettype wire

// ==== hw/retSiteTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module retSiteTable
    import predConfigPkg::*;
    import predTypesPkg::*;
(
    input  wire              clk,
    input  wire              rst,

    input  wire              fetchValid,
    input  wire PcHw_t       fetchPc,

    input  wire RetUpdKind_t updKind,
    input  wire PcHw_t       updAddr,
    input  wire              updCompr,

    input  wire              popTaken,
    output logic             hit,
    output FetchOff_t        hitOffs,
    output logic             hitCompr
);

    // per way state, control bits first, then the payload
    logic                   tblValid [RET_TABLE_SETS][RET_TABLE_WAYS];
    logic                   tblUsed  [RET_TABLE_SETS][RET_TABLE_WAYS];
    logic                   tblCompr [RET_TABLE_SETS][RET_TABLE_WAYS];
    logic [RET_TAG_LEN-1:0] tblTag   [RET_TABLE_SETS][RET_TABLE_WAYS];
    FetchOff_t              tblOffs  [RET_TABLE_SETS][RET_TABLE_WAYS];

    logic [RET_SET_LEN-1:0] lookupSet;
    logic [RET_TAG_LEN-1:0] lookupTag;
    FetchOff_t              lookupOffs;
    logic [RET_WAY_LEN-1:0] hitWay;

    logic [RET_SET_LEN-1:0] updSet;
    logic [RET_TAG_LEN-1:0] updTag;
    FetchOff_t              updOffs;
    logic [RET_WAY_LEN-1:0] insWay;
    logic                   insOk;
    logic                   dupFound;
    logic                   doInsert;
    logic                   dupAny;

    assign lookupOffs = fetchPc[FETCH_OFF_LEN-1:0];
    assign lookupSet  = fetchPc[FETCH_OFF_LEN +: RET_SET_LEN];
    assign lookupTag  = fetchPc[FETCH_OFF_LEN + RET_SET_LEN +: RET_TAG_LEN];

    assign updOffs = updAddr[FETCH_OFF_LEN-1:0];
    assign updSet  = updAddr[FETCH_OFF_LEN +: RET_SET_LEN];
    assign updTag  = updAddr[FETCH_OFF_LEN + RET_SET_LEN +: RET_TAG_LEN];

    // nearest return site at or after the fetch offset wins
    always_comb begin
        hit      = 1'b0;
        hitOffs  = '0;
        hitCompr = 1'b0;
        hitWay   = '0;
        if (fetchValid) begin
            for (int w = 0; w < RET_TABLE_WAYS; w++) begin
                if (tblValid[lookupSet][w] && tblTag[lookupSet][w] == lookupTag &&
                    tblOffs[lookupSet][w] >= lookupOffs &&
                    (!hit || tblOffs[lookupSet][w] < hitOffs)) begin
                    hit      = 1'b1;
                    hitOffs  = tblOffs[lookupSet][w];
                    hitCompr = tblCompr[lookupSet][w];
                    hitWay   = w[RET_WAY_LEN-1:0];
                end
            end
        end
    end

    // insert victim is the first way that is free or was never used by a fetch pop
    always_comb begin
        dupFound = 1'b0;
        insOk    = 1'b0;
        insWay   = '0;
        for (int w = 0; w < RET_TABLE_WAYS; w++) begin
            if (tblValid[updSet][w] && tblTag[updSet][w] == updTag &&
                tblOffs[updSet][w] == updOffs) begin
                dupFound = 1'b1;
            end
            if (!insOk && (!tblValid[updSet][w] || !tblUsed[updSet][w])) begin
                insOk  = 1'b1;
                insWay = w[RET_WAY_LEN-1:0];
            end
        end
    end

    assign doInsert = (updKind == UPD_RET) && insOk && !dupFound;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < RET_TABLE_SETS; s++) begin
                for (int w = 0; w < RET_TABLE_WAYS; w++) begin
                    tblValid[s][w] <= 1'b0;
                    tblUsed[s][w]  <= 1'b0;
                end
            end
        end else begin
            if (doInsert) begin
                tblValid[updSet][insWay] <= 1'b1;
                tblUsed[updSet][insWay]  <= 1'b0;
            end else if (updKind == UPD_CLEAN) begin
                for (int w = 0; w < RET_TABLE_WAYS; w++) begin
                    tblValid[updSet][w] <= 1'b0;
                end
            end
            // the stack only pops while decode is idle, so this never collides with an insert
            if (popTaken) begin
                tblUsed[lookupSet][hitWay] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doInsert) begin
            tblTag[updSet][insWay]   <= updTag;
            tblOffs[updSet][insWay]  <= updOffs;
            tblCompr[updSet][insWay] <= updCompr;
        end
    end

    always_comb begin
        dupAny = 1'b0;
        for (int s = 0; s < RET_TABLE_SETS; s++) begin
            for (int a = 0; a < RET_TABLE_WAYS; a++) begin
                for (int b = a + 1; b < RET_TABLE_WAYS; b++) begin
                    if (tblValid[s][a] && tblValid[s][b] && tblTag[s][a] == tblTag[s][b] &&
                        tblOffs[s][a] == tblOffs[s][b]) begin
                        dupAny = 1'b1;
                    end
                end
            end
        end
    end

    // the stack must never pop on a return the table did not predict
    popNeedsHit: assert property (@(posedge clk) disable iff (rst) popTaken |-> hit);

    noDoubleInsert: assert property (
        @(posedge clk) disable iff (rst) (updKind == UPD_RET) |=> !dupAny
    );

endmodule

`default_nettype wire

// ==== hw/predTypesPkg.sv ====
`default_nettype none

package predTypesPkg;

    import predConfigPkg::*;

    // instruction addresses are kept in halfword units, bit 0 of the byte address dropped
    typedef logic [30:0] PcHw_t;

    // halfword position inside one fetch block
    typedef logic [FETCH_OFF_LEN-1:0] FetchOff_t;

    // stack pointer, wraps modulo the stack size
    typedef logic [$clog2(RET_STACK_SIZE)-1:0] RetStackIdx_t;

    // kind of correction sent back from decode
    typedef enum logic [1:0] {
        UPD_NONE  = 2'd0,
        UPD_CALL  = 2'd1,
        UPD_RET   = 2'd2,
        UPD_CLEAN = 2'd3
    } RetUpdKind_t;

endpackage

`default_nettype wire

// ==== hw/predConfigPkg.sv ====
`default_nettype none

// sizing of the return-address prediction block
package predConfigPkg;

    // return-address stack depth, a power of two so the index wraps naturally
    localparam int RET_STACK_SIZE = 4;

    // return-site table geometry
    localparam int RET_TABLE_SETS = 4;
    localparam int RET_TABLE_WAYS = 2;
    localparam int RET_TAG_LEN    = 8;

    // a fetch block holds eight halfwords
    localparam int FETCH_OFF_LEN  = 3;

    // derived widths of the table set index and the way number
    localparam int RET_SET_LEN    = $clog2(RET_TABLE_SETS);
    localparam int RET_WAY_LEN    = $clog2(RET_TABLE_WAYS);

endpackage

`default_nettype wire
